// ==== verif/ps2_stim.txt ====
# scan byte (hex), expected key_code (hex), strobe (0 none, 1 acked, 2 left to time out),
# expected kbd_reset, expected caps_lock, test name
1C 20 1 0 0 make_break
F0 00 0 0 0 make_break
1C A0 1 0 0 make_break
0E 00 0 0 0 unlisted
1C 20 1 0 0 typematic
1C 00 0 0 0 typematic
F0 00 0 0 0 typematic
1C A0 1 0 0 typematic
1C 20 1 0 0 typematic
E0 00 0 0 0 extended
11 65 1 0 0 extended
E0 00 0 0 0 extended
F0 00 0 0 0 extended
11 E5 1 0 0 extended
E0 00 0 0 0 extended
75 4C 1 0 0 extended
11 64 1 0 0 ext_cleared
58 62 1 0 1 caps_lock
F0 00 0 0 1 caps_lock
58 00 0 0 1 caps_lock
58 00 0 0 0 caps_lock
F0 00 0 0 0 caps_lock
58 E2 1 0 0 caps_lock
14 63 1 0 0 reset_combo
E0 00 0 0 0 reset_combo
11 65 1 1 0 reset_combo
F0 00 0 1 0 reset_combo
14 E3 1 0 0 reset_combo
29 40 2 0 0 hold_timeout

// ==== files.f ====
hdl/ps2kbd_pkg.sv
hdl/ps2_rx.sv
hdl/scancode_map.sv
hdl/key_event_filter.sv
hdl/ps2_hold_ctrl.sv
hdl/ps2_keyboard.sv
verif/tb_ps2_keyboard.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing
TOP       := tb_ps2_keyboard
FILELIST  := files.f
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== verif/tb_ps2_keyboard.sv ====
// clock, reset, PS/2 device model, stimulus reader, checks and run limit for ps2_keyboard
`timescale 1ns/1ps

module tb_ps2_keyboard
	import ps2kbd_pkg::*;
();

	logic clk = 1'b0;
	logic reset, ps2_clk_in, ps2_dat_in, key_ack;
	logic ps2_clk_hold, key_strobe, caps_lock, kbd_reset;
	amiga_key_t key_code;

	scan_code_t scan_q[$];
	amiga_key_t key_q[$];
	int flag_q[$], rst_q[$], caps_q[$];	// flag 0 none, 1 acked, 2 timed out
	string name_q[$];

	int errors = 0;
	int strobes = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int strobe_cycle = 0;
	int seed = 32'h3288;
	amiga_key_t seen_code = '0;
	logic hold_due = 1'b0;
	string cur_name = "";

	ps2_keyboard #(.TIMEOUT_BITS(10)) dut0 (
		.clk(clk), .reset(reset), .ps2_clk_in(ps2_clk_in), .ps2_dat_in(ps2_dat_in),
		.ps2_clk_hold(ps2_clk_hold), .key_code(key_code), .key_strobe(key_strobe),
		.key_ack(key_ack), .caps_lock(caps_lock), .kbd_reset(kbd_reset)
	);

	always #4 clk = ~clk;

	// ------------------------------------------------------------------------
	// monitor sampling mid-cycle
	// ------------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (hold_due && !ps2_clk_hold)
		begin
			$display("Mismatch %s: ps2_clk_hold after key strobe %h expected 1, actual %b",
				cur_name, seen_code, ps2_clk_hold);
			errors++;
		end
		hold_due = key_strobe;
		if (key_strobe)
		begin
			seen_code = key_code;
			strobe_cycle = cycles;
			strobes++;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("run stopped after %0d cycles, DUT never finished", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// one frame lsb first with 6 clocks per half bit
	task automatic send_byte(input scan_code_t b);
		logic [FRAME_BITS-1:0] frame;
		int i;
		frame = {1'b1, ~^b, b, 1'b0};	// stop, odd parity, data, start
		for (i = 0; i < FRAME_BITS; i++)
		begin
			@(posedge clk);
			ps2_dat_in <= frame[i];
			repeat (6) @(posedge clk);
			ps2_clk_in <= 1'b0;
			repeat (6) @(posedge clk);
			ps2_clk_in <= 1'b1;
		end
	endtask

	// keyboard must stay quiet while the clock line is held
	task automatic wait_hold_release();
		@(posedge clk);
		@(negedge clk);
		while (ps2_clk_hold && (cycles - strobe_cycle) <= 1026)
			@(negedge clk);
		if (ps2_clk_hold)
		begin
			$display("ps2_clk_hold still high 1026 cycles after the last key strobe");
			errors++;
		end
	endtask

	initial
	begin : stimulus
		int fd, code, flag, rst, caps, delay, n, exp_strobes;
		logic [7:0] scan, key;
		string line, name;
		reset = 1'b1;
		ps2_clk_in = 1'b1;
		ps2_dat_in = 1'b1;
		key_ack = 1'b0;
		exp_strobes = 0;
		fd = $fopen("verif/ps2_stim.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open stimulus file verif/ps2_stim.txt");
			errors++;
		end
		while (fd != 0 && !$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code != 0 && line.len() > 1 && line[0] != "#" &&
				$sscanf(line, "%h %h %d %d %d %s", scan, key, flag, rst, caps, name) == 6)
			begin
				scan_q.push_back(scan);
				key_q.push_back(key);
				flag_q.push_back(flag);
				rst_q.push_back(rst);
				caps_q.push_back(caps);
				name_q.push_back(name);
			end
		end
		if (fd != 0)
			$fclose(fd);
		cycle_limit = scan_q.size() * 200 + 4000;

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);

		foreach (scan_q[i])
		begin
			wait_hold_release();
			cur_name = name_q[i];
			send_byte(scan_q[i]);
			if (flag_q[i] != 0)
			begin
				exp_strobes++;
				n = 0;
				while (strobes < exp_strobes && n < 60)
				begin
					n++;
					@(posedge clk);
				end
				if (strobes < exp_strobes)
				begin
					$display("%s: no key strobe for scan code %h", name_q[i], scan_q[i]);
					errors++;
					exp_strobes = strobes;
				end
				else if (seen_code !== key_q[i])
				begin
					$display("Mismatch %s: key_code expected %h, actual %h",
						name_q[i], key_q[i], seen_code);
					errors++;
				end
			end
			repeat (8) @(posedge clk);
			if (strobes != exp_strobes)
			begin
				$display("%s: extra key strobe after scan code %h", name_q[i], scan_q[i]);
				errors++;
				exp_strobes = strobes;
			end
			@(negedge clk);
			if (kbd_reset !== (rst_q[i] != 0))
			begin
				$display("Mismatch %s: kbd_reset expected %0d, actual %b",
					name_q[i], rst_q[i], kbd_reset);
				errors++;
			end
			if (caps_lock !== (caps_q[i] != 0))
			begin
				$display("Mismatch %s: caps_lock expected %0d, actual %b",
					name_q[i], caps_q[i], caps_lock);
				errors++;
			end
			if (flag_q[i] == 1)
			begin
				delay = $unsigned($random(seed)) % 41;	// host reaction time
				repeat (delay) @(posedge clk);
				@(posedge clk);
				key_ack <= 1'b1;
				@(negedge clk);
				if (ps2_clk_hold !== 1'b1)
				begin
					$display("Mismatch %s: ps2_clk_hold at key_ack expected 1, actual %b",
						name_q[i], ps2_clk_hold);
					errors++;
				end
				@(posedge clk);
				key_ack <= 1'b0;
				@(negedge clk);
				if (ps2_clk_hold !== 1'b0)
				begin
					$display("Mismatch %s: ps2_clk_hold expected 0, actual %b",
						name_q[i], ps2_clk_hold);
					errors++;
				end
			end
		end
		wait_hold_release();	// last key may be left to time out

		$display("%0d scan codes, %0d key strobes, %0d errors", scan_q.size(), strobes, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== hdl/ps2_keyboard.sv ====
// top level of the PS/2 to amiga keyboard front end
`timescale 1ns/1ps

module ps2_keyboard
	import ps2kbd_pkg::*;
#(
	parameter int TIMEOUT_BITS = 19	// about 74 ms at 7 MHz
)
(
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2_clk_in,
	input  logic       ps2_dat_in,
	output logic       ps2_clk_hold,	// board drives the clock line low
	output amiga_key_t key_code,
	output logic       key_strobe,
	input  logic       key_ack,
	output logic       caps_lock,
	output logic       kbd_reset
);

	logic frame_ready;
	scan_code_t frame_code;
	logic key_valid;
	logic is_ctrl, is_alt_l, is_alt_r, is_caps;

	ps2_rx rx0 (
		.clk(clk), .reset(reset),
		.ps2_clk_in(ps2_clk_in), .ps2_dat_in(ps2_dat_in),
		.frame_ready(frame_ready), .frame_code(frame_code)
	);

	scancode_map map0 (
		.clk(clk), .reset(reset),
		.frame_ready(frame_ready), .frame_code(frame_code),
		.key_valid(key_valid), .key_code(key_code),
		.is_ctrl(is_ctrl), .is_alt_l(is_alt_l), .is_alt_r(is_alt_r), .is_caps(is_caps)
	);

	key_event_filter filt0 (
		.clk(clk), .reset(reset),
		.key_valid(key_valid), .key_code(key_code),
		.is_ctrl(is_ctrl), .is_alt_l(is_alt_l), .is_alt_r(is_alt_r), .is_caps(is_caps),
		.key_strobe(key_strobe), .caps_lock(caps_lock), .kbd_reset(kbd_reset)
	);

	ps2_hold_ctrl #(.TIMEOUT_BITS(TIMEOUT_BITS)) hold0 (
		.clk(clk), .reset(reset),
		.key_strobe(key_strobe), .key_ack(key_ack),
		.ps2_clk_hold(ps2_clk_hold)
	);

endmodule

// ==== hdl/ps2_hold_ctrl.sv ====
// keyboard hold-off state machine and timeout counter
`timescale 1ns/1ps

module ps2_hold_ctrl
	import ps2kbd_pkg::*;
#(
	parameter int TIMEOUT_BITS = 19
)
(
	input  logic clk,
	input  logic reset,
	input  logic key_strobe,
	input  logic key_ack,
	output logic ps2_clk_hold
);

	hold_state_t state, next_state;
	logic [TIMEOUT_BITS:0] hold_count;	// runs up to 2**TIMEOUT_BITS
	logic timed_out;

	assign timed_out = hold_count[TIMEOUT_BITS];

	always_comb
	begin
		next_state = state;
		case (state)
			WAIT_KEY:
				if (key_strobe)
					next_state = HOLD_OFF;
			HOLD_OFF:
				if (key_ack || timed_out)	// host took the key or gave up
					next_state = WAIT_KEY;
			default:
				next_state = WAIT_KEY;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= WAIT_KEY;
			hold_count <= '0;
			ps2_clk_hold <= 1'b0;
		end
		else
		begin
			state <= next_state;
			hold_count <= (state == HOLD_OFF) ? hold_count + 1'b1 : '0;
			ps2_clk_hold <= (next_state == HOLD_OFF);	// clock line low while waiting
		end
	end

endmodule

// ==== hdl/key_event_filter.sv ====
// typematic filter, caps lock memory, key strobe, reset-combination detect
`timescale 1ns/1ps

module key_event_filter
	import ps2kbd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       key_valid,
	input  amiga_key_t key_code,
	input  logic       is_ctrl,
	input  logic       is_alt_l,
	input  logic       is_alt_r,
	input  logic       is_caps,
	output logic       key_strobe,
	output logic       caps_lock,
	output logic       kbd_reset
);

	amiga_key_t last_key;
	logic key_up;
	logic key_equal;
	logic key_dup;
	logic ctrl_up, alt_l_up, alt_r_up;	// 1 while released

	assign key_up = key_code[KEY_UP_BIT];
	assign key_equal = (last_key[6:0] == key_code[6:0]);
	assign key_dup = key_equal && (last_key[KEY_UP_BIT] == key_up);	// typematic repeat

	// last key seen; only its own upstroke replaces a downstroke
	always_ff @(posedge clk)
	begin
		if (reset)
			last_key <= '0;
		else if (key_valid && !key_up)
			last_key <= key_code;
		else if (key_valid && key_up && key_equal)
			last_key <= key_code;
	end

	// amiga caps lock is a latching key
	always_ff @(posedge clk)
	begin
		if (reset)
			caps_lock <= 1'b0;
		else if (key_valid && !key_up && is_caps && !key_dup)
			caps_lock <= ~caps_lock;
	end

	// caps events on both edges are swallowed while the lock is on
	assign key_strobe = key_valid && !key_dup && !(caps_lock && is_caps);

	// --------------------------------------------------------------------------
	// keyboard reset on ctrl (or caps) + left alt + right alt
	// --------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ctrl_up <= 1'b1;
			alt_l_up <= 1'b1;
			alt_r_up <= 1'b1;
		end
		else if (key_valid)
		begin
			if (is_ctrl || is_caps)
				ctrl_up <= key_up;
			if (is_alt_l)
				alt_l_up <= key_up;
			if (is_alt_r)
				alt_r_up <= key_up;
		end
	end

	assign kbd_reset = ~(ctrl_up | alt_l_up | alt_r_up);

endmodule

// ==== hdl/scancode_map.sv ====
// set 2 scan code to amiga key table with E0/F0 prefix tracking
`timescale 1ns/1ps

module scancode_map
	import ps2kbd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       frame_ready,
	input  scan_code_t frame_code,
	output logic       key_valid,
	output amiga_key_t key_code,
	output logic       is_ctrl,
	output logic       is_alt_l,
	output logic       is_alt_r,
	output logic       is_caps
);

	localparam keymap_entry_t WORD_EXT = keymap_entry_t'((1 << KM_PROTO) | (1 << KM_PFX_EXT));
	localparam keymap_entry_t WORD_REL = keymap_entry_t'((1 << KM_PROTO) | (1 << KM_PFX_REL));
	localparam keymap_entry_t WORD_ACK = keymap_entry_t'((1 << KM_PROTO) | (1 << KM_PFX_ACK));

	keymap_entry_t keymap_word;
	logic lookup_d;	// table output is fresh
	logic ext_flag;
	logic rel_flag;

	always_ff @(posedge clk)
	begin
		if (reset)
			lookup_d <= 1'b0;
		else
			lookup_d <= frame_ready;
	end

	// prefix state is updated when the table word is out
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ext_flag <= 1'b0;
			rel_flag <= 1'b0;
		end
		else if (lookup_d && keymap_word[KM_PROTO] && keymap_word[KM_PFX_EXT])
			ext_flag <= 1'b1;
		else if (lookup_d && keymap_word[KM_PROTO] && keymap_word[KM_PFX_REL])
			rel_flag <= 1'b1;
		else if (lookup_d && !(keymap_word[KM_PROTO] && keymap_word[KM_PFX_ACK]))
		begin
			// a key ends the sequence
			ext_flag <= 1'b0;
			rel_flag <= 1'b0;
		end
	end

	assign key_valid = keymap_word[KM_VALID] & lookup_d;
	assign key_code = {rel_flag, keymap_word[6:0]};
	assign is_ctrl = keymap_word[KM_CTRL];
	assign is_alt_l = keymap_word[KM_ALT_L];
	assign is_alt_r = keymap_word[KM_ALT_R];
	assign is_caps = keymap_word[KM_CAPS];

	// --------------------------------------------------------------------------
	// keymap table indexed by {extended, scan code}
	// --------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (frame_ready)
		begin
			case ({ext_flag, frame_code})
				9'h01c:	keymap_word <= 16'h8020;	// a
				9'h032:	keymap_word <= 16'h8035;	// b
				9'h021:	keymap_word <= 16'h8033;	// c
				9'h023:	keymap_word <= 16'h8022;	// d
				9'h024:	keymap_word <= 16'h8012;	// e
				9'h02b:	keymap_word <= 16'h8023;	// f
				9'h034:	keymap_word <= 16'h8024;	// g
				9'h033:	keymap_word <= 16'h8025;	// h
				9'h043:	keymap_word <= 16'h8017;	// i
				9'h03b:	keymap_word <= 16'h8026;	// j
				9'h042:	keymap_word <= 16'h8027;	// k
				9'h04b:	keymap_word <= 16'h8028;	// l
				9'h03a:	keymap_word <= 16'h8037;	// m
				9'h031:	keymap_word <= 16'h8036;	// n
				9'h044:	keymap_word <= 16'h8018;	// o
				9'h04d:	keymap_word <= 16'h8019;	// p
				9'h015:	keymap_word <= 16'h8010;	// q
				9'h02d:	keymap_word <= 16'h8013;	// r
				9'h01b:	keymap_word <= 16'h8021;	// s
				9'h02c:	keymap_word <= 16'h8014;	// t
				9'h03c:	keymap_word <= 16'h8016;	// u
				9'h02a:	keymap_word <= 16'h8034;	// v
				9'h01d:	keymap_word <= 16'h8011;	// w
				9'h022:	keymap_word <= 16'h8032;	// x
				9'h035:	keymap_word <= 16'h8015;	// y
				9'h01a:	keymap_word <= 16'h8031;	// z
				9'h016:	keymap_word <= 16'h8001;	// 1
				9'h01e:	keymap_word <= 16'h8002;	// 2
				9'h026:	keymap_word <= 16'h8003;	// 3
				9'h025:	keymap_word <= 16'h8004;	// 4
				9'h02e:	keymap_word <= 16'h8005;	// 5
				9'h036:	keymap_word <= 16'h8006;	// 6
				9'h03d:	keymap_word <= 16'h8007;	// 7
				9'h03e:	keymap_word <= 16'h8008;	// 8
				9'h046:	keymap_word <= 16'h8009;	// 9
				9'h045:	keymap_word <= 16'h800a;	// 0
				9'h029:	keymap_word <= 16'h8040;	// space
				9'h05a:	keymap_word <= 16'h8044;	// enter
				9'h012:	keymap_word <= 16'h8060;	// left shift
				9'h059:	keymap_word <= 16'h8061;	// right shift
				9'h014:	keymap_word <= 16'hc063;	// ctrl
				9'h011:	keymap_word <= 16'ha064;	// left alt
				9'h111:	keymap_word <= 16'h9065;	// right alt
				9'h058:	keymap_word <= 16'h8862;	// caps lock
				9'h175:	keymap_word <= 16'h804c;	// cursor up
				9'h172:	keymap_word <= 16'h804d;	// cursor down
				9'h174:	keymap_word <= 16'h804e;	// cursor right
				9'h16b:	keymap_word <= 16'h804f;	// cursor left
				// protocol bytes look the same with or without E0 before them
				{1'b0, SCAN_EXT}, {1'b1, SCAN_EXT}:	keymap_word <= WORD_EXT;
				{1'b0, SCAN_REL}, {1'b1, SCAN_REL}:	keymap_word <= WORD_REL;
				{1'b0, SCAN_ACK}, {1'b1, SCAN_ACK}:	keymap_word <= WORD_ACK;
				default:	keymap_word <= '0;	// not mapped
			endcase
		end
	end

endmodule

// ==== hdl/ps2_rx.sv ====
// PS/2 line synchronizers, clock falling-edge detect and frame shifter
`timescale 1ns/1ps

module ps2_rx
	import ps2kbd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2_clk_in,
	input  logic       ps2_dat_in,
	output logic       frame_ready,
	output scan_code_t frame_code
);

	logic clk_s1, clk_s2, clk_prev;
	logic dat_s1, dat_s2;
	logic clk_fall;
	logic [FRAME_BITS-1:0] shift_reg;

	// two-stage synchronizers with the lines idling high
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			clk_s1 <= 1'b1;
			clk_s2 <= 1'b1;
			clk_prev <= 1'b1;
			dat_s1 <= 1'b1;
			dat_s2 <= 1'b1;
		end
		else
		begin
			clk_s1 <= ps2_clk_in;
			clk_s2 <= clk_s1;
			clk_prev <= clk_s2;
			dat_s1 <= ps2_dat_in;
			dat_s2 <= dat_s1;
		end
	end

	assign clk_fall = clk_prev & ~clk_s2;	// keyboard data is valid here

	// lsb-first frame shifter; the start bit lands in bit 0 after the 11th edge
	always_ff @(posedge clk)
	begin
		if (reset || frame_ready)
			shift_reg <= '1;
		else if (clk_fall)
			shift_reg <= {dat_s2, shift_reg[FRAME_BITS-1:1]};
	end

	assign frame_ready = ~shift_reg[0];
	assign frame_code = shift_reg[8:1];	// parity and stop are ignored

endmodule

// ==== hdl/ps2kbd_pkg.sv ====
// widths, key code types, keymap word bit positions, protocol codes, hold-off states
package ps2kbd_pkg;

	// --------------------------------------------------------------------------
	// data types
	// --------------------------------------------------------------------------
	typedef logic [7:0] scan_code_t;	// one PS/2 scan code byte
	typedef logic [7:0] amiga_key_t;	// amiga raw key, msb is upstroke
	typedef logic [15:0] keymap_entry_t;	// one keymap table word

	// upstroke flag inside amiga_key_t
	localparam int KEY_UP_BIT = 7;

	// start, 8 data, parity, stop
	localparam int FRAME_BITS = 11;

	// --------------------------------------------------------------------------
	// keymap word layout
	// bits 6..0 hold the amiga key number for normal keys
	// --------------------------------------------------------------------------
	localparam int KM_VALID = 15;	// key present in table
	localparam int KM_CTRL = 14;
	localparam int KM_ALT_L = 13;
	localparam int KM_ALT_R = 12;
	localparam int KM_CAPS = 11;
	localparam int KM_PROTO = 7;	// protocol byte, not a key

	// protocol sub-codes, only meaningful with KM_PROTO
	localparam int KM_PFX_EXT = 0;
	localparam int KM_PFX_REL = 1;
	localparam int KM_PFX_ACK = 2;

	// scan code set 2 protocol bytes
	localparam scan_code_t SCAN_EXT = 8'hE0;	// extended key prefix
	localparam scan_code_t SCAN_REL = 8'hF0;	// break prefix
	localparam scan_code_t SCAN_ACK = 8'hFA;	// command acknowledge

	// keyboard hold-off controller
	typedef enum logic
	{
		WAIT_KEY,
		HOLD_OFF
	} hold_state_t;

endpackage
